// File: pcie_pkg.sv
/*
  Shared widths, FIFO sizes, BAR map constants and FSM state types for the
  PCIe endpoint receive glue. Modules import what they need from here.
*/
package pcie_pkg;

  // Receive stream
  localparam int WORD_W         = 32;
  localparam int BAR_HIT_W      = 7;

  // BAR hit bit that selects each path
  localparam int CONTROL_SELECT = 0;
  localparam int DATA_SELECT    = 1;

  // FIFO address widths, 32 and 128 words
  localparam int CTRL_FIFO_AW   = 5;
  localparam int DATA_FIFO_AW   = 7;

  // Configuration space layout
  localparam int NUM_BARS        = 6;
  localparam int BAR_IDX_W       = $clog2(NUM_BARS);
  localparam int BAR_DWADDR_BASE = 4;
  localparam int CFG_DWADDR_W    = 10;

  // Interrupt channel number
  localparam int INT_CHAN_W     = 8;

  // BAR sweep sequencer
  typedef enum logic [1:0] {
    BAR_IDLE,
    BAR_REQ,
    BAR_WAIT
  } bar_state_t;

  // Interrupt request handshake
  typedef enum logic {
    INT_IDLE,
    INT_SEND
  } int_state_t;

endpackage

// File: pcie_rx_router.sv
/*
  Combinational steering of the receive stream. Valid goes to the FIFO picked
  by the BAR hit and that FIFO's ready comes back to the core.
*/
`timescale 1ns/1ns

module pcie_rx_router (
  input  logic                           i_rx_valid,
  input  logic [pcie_pkg::BAR_HIT_W-1:0] i_rx_bar_hit,
  input  logic                           i_ctrl_ready,
  input  logic                           i_data_ready,
  output logic                           o_rx_ready,
  output logic                           o_ctrl_valid,
  output logic                           o_data_valid
);

  import pcie_pkg::*;

  logic ctrl_sel;
  logic data_sel;

  // BAR0 feeds the control path, BAR1 the data path
  assign ctrl_sel = i_rx_bar_hit[CONTROL_SELECT];
  assign data_sel = i_rx_bar_hit[DATA_SELECT];

  assign o_ctrl_valid = i_rx_valid & ctrl_sel;
  assign o_data_valid = i_rx_valid & data_sel;

  // Control wins if both were ever set
  // No hit on either BAR stalls the stream
  always_comb begin
    if (ctrl_sel) begin
      o_rx_ready = i_ctrl_ready;
    end else if (data_sel) begin
      o_rx_ready = i_data_ready;
    end else begin
      o_rx_ready = 1'b0;
    end
  end

  // A beat must belong to exactly one path or it would be written twice
  always_comb begin
    if (i_rx_valid) begin
      assert (!(ctrl_sel && data_sel))
        else $error("rx beat hits both control and data BARs");
    end
  end

endmodule

// File: pcie_stream_fifo.sv
/*
  Synchronous valid/ready FIFO holding a data word and its last flag.
  Depth is 2**ADDR_W. A word written on one edge can leave on the next.
*/
`timescale 1ns/1ns

module pcie_stream_fifo #(
  parameter int ADDR_W = 5
) (
  input  logic                        clk_62p5,
  input  logic                        pcie_reset,
  input  logic [pcie_pkg::WORD_W-1:0] i_data,
  input  logic                        i_last,
  input  logic                        i_valid,
  output logic                        o_ready,
  output logic [pcie_pkg::WORD_W-1:0] o_data,
  output logic                        o_last,
  output logic                        o_valid,
  input  logic                        i_ready
);

  import pcie_pkg::*;

  // Last flag sits in the top bit of each entry
  logic [WORD_W:0]   mem [0:(1 << ADDR_W) - 1];
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [ADDR_W:0]   count_q;
  logic              wr_en;
  logic              rd_en;

  // Top count bit set means full
  assign o_ready = ~count_q[ADDR_W];
  assign o_valid = (count_q != '0);

  assign wr_en = i_valid & o_ready;
  assign rd_en = o_valid & i_ready;

  assign o_data = mem[rd_ptr_q][WORD_W-1:0];
  assign o_last = mem[rd_ptr_q][WORD_W];

  always_ff @(posedge clk_62p5) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= {i_last, i_data};
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // A write reaches the head slot only when the FIFO is empty
  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    (wr_en && (wr_ptr_q == rd_ptr_q)) |-> (count_q == '0));

  // Head word holds still while the consumer stalls
  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    (o_valid && !i_ready) |=> ($stable(o_data) && $stable(o_last)));

endmodule

// File: pcie_bar_reader.sv
/*
  Configuration-space sequencer. A strobe starts a sweep that reads BAR0 to
  BAR5 one at a time through the core's config read port and holds the values.
*/
`timescale 1ns/1ns

module pcie_bar_reader (
  input  logic                              clk_62p5,
  input  logic                              pcie_reset,
  input  logic                              i_read_bar_stb,
  input  logic [pcie_pkg::WORD_W-1:0]       i_cfg_do,
  input  logic                              i_cfg_rd_wr_done,
  output logic                              o_cfg_rd_en,
  output logic [pcie_pkg::CFG_DWADDR_W-1:0] o_cfg_dwaddr,
  output logic                              o_bar_busy,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr0,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr1,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr2,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr3,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr4,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr5
);

  import pcie_pkg::*;

  bar_state_t           state_q;
  logic [BAR_IDX_W-1:0] bar_idx_q;
  logic                 rd_en_q;
  logic [WORD_W-1:0]    bar_q [0:NUM_BARS-1];

  // BARn lives at dword BAR_DWADDR_BASE + n
  assign o_cfg_dwaddr = CFG_DWADDR_W'(BAR_DWADDR_BASE + bar_idx_q);
  assign o_cfg_rd_en  = rd_en_q;
  assign o_bar_busy   = (state_q != BAR_IDLE);

  assign o_bar_addr0 = bar_q[0];
  assign o_bar_addr1 = bar_q[1];
  assign o_bar_addr2 = bar_q[2];
  assign o_bar_addr3 = bar_q[3];
  assign o_bar_addr4 = bar_q[4];
  assign o_bar_addr5 = bar_q[5];

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      state_q   <= BAR_IDLE;
      bar_idx_q <= '0;
      rd_en_q   <= 1'b0;
      for (int i = 0; i < NUM_BARS; i++) begin
        bar_q[i] <= '0;
      end
    end else begin
      case (state_q)
        BAR_IDLE: begin
          if (i_read_bar_stb) begin
            bar_idx_q <= '0;
            rd_en_q   <= 1'b1;
            state_q   <= BAR_REQ;
          end
        end
        BAR_REQ: begin
          // Read stays posted until the core reports done
          if (i_cfg_rd_wr_done) begin
            bar_q[bar_idx_q] <= i_cfg_do;
            rd_en_q          <= 1'b0;
            state_q          <= BAR_WAIT;
          end
        end
        BAR_WAIT: begin
          // One idle cycle between reads
          if (bar_idx_q == BAR_IDX_W'(NUM_BARS - 1)) begin
            state_q <= BAR_IDLE;
          end else begin
            bar_idx_q <= bar_idx_q + 1'b1;
            rd_en_q   <= 1'b1;
            state_q   <= BAR_REQ;
          end
        end
        default: begin
          rd_en_q <= 1'b0;
          state_q <= BAR_IDLE;
        end
      endcase
    end
  end

  // Read enable only ever appears inside a sweep
  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    (state_q == BAR_IDLE) |-> !o_cfg_rd_en);

endmodule

// File: pcie_interrupt_ctrl.sv
/*
  Interrupt requester. A user strobe latches the channel and raises a request
  to the core, held until the core acknowledges with interrupt ready.
*/
`timescale 1ns/1ns

module pcie_interrupt_ctrl (
  input  logic                            clk_62p5,
  input  logic                            pcie_reset,
  input  logic                            i_interrupt_stb,
  input  logic [pcie_pkg::INT_CHAN_W-1:0] i_interrupt_channel,
  input  logic                            i_cfg_interrupt_rdy,
  output logic                            o_cfg_interrupt,
  output logic [pcie_pkg::INT_CHAN_W-1:0] o_cfg_interrupt_di
);

  import pcie_pkg::*;

  int_state_t            state_q;
  logic [INT_CHAN_W-1:0] chan_q;

  assign o_cfg_interrupt    = (state_q == INT_SEND);
  assign o_cfg_interrupt_di = chan_q;

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      state_q <= INT_IDLE;
      chan_q  <= '0;
    end else begin
      case (state_q)
        INT_IDLE: begin
          if (i_interrupt_stb) begin
            chan_q  <= i_interrupt_channel;
            state_q <= INT_SEND;
          end
        end
        INT_SEND: begin
          // Strobes here are dropped, the pending request keeps its channel
          if (i_cfg_interrupt_rdy) begin
            state_q <= INT_IDLE;
          end
        end
        default: state_q <= INT_IDLE;
      endcase
    end
  end

  // Request is held with a steady channel until the core takes it
  assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    (o_cfg_interrupt && !i_cfg_interrupt_rdy)
      |=> (o_cfg_interrupt && $stable(o_cfg_interrupt_di)));

endmodule

// File: pcie_endpoint_top.sv
/*
  Receive-side glue of the PCIe endpoint. Routes BAR0 and BAR1 traffic into
  the control and data FIFOs, runs the BAR sweep and the interrupt handshake.
*/
`timescale 1ns/1ns

module pcie_endpoint_top (
  input  logic                              clk_62p5,
  input  logic                              pcie_reset,

  // Receive stream from the core
  input  logic [pcie_pkg::WORD_W-1:0]       i_rx_data,
  input  logic                              i_rx_last,
  input  logic                              i_rx_valid,
  input  logic [pcie_pkg::BAR_HIT_W-1:0]    i_rx_bar_hit,
  output logic                              o_rx_ready,

  // Control FIFO drain
  output logic [pcie_pkg::WORD_W-1:0]       o_cmd_data,
  output logic                              o_cmd_last,
  output logic                              o_cmd_valid,
  input  logic                              i_cmd_ready,

  // Data FIFO drain
  output logic [pcie_pkg::WORD_W-1:0]       o_dat_data,
  output logic                              o_dat_last,
  output logic                              o_dat_valid,
  input  logic                              i_dat_ready,

  // Configuration read port and BAR results
  input  logic                              i_read_bar_stb,
  output logic                              o_cfg_rd_en,
  output logic [pcie_pkg::CFG_DWADDR_W-1:0] o_cfg_dwaddr,
  input  logic [pcie_pkg::WORD_W-1:0]       i_cfg_do,
  input  logic                              i_cfg_rd_wr_done,
  output logic                              o_bar_busy,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr0,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr1,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr2,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr3,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr4,
  output logic [pcie_pkg::WORD_W-1:0]       o_bar_addr5,

  // Interrupt port
  input  logic                              i_interrupt_stb,
  input  logic [pcie_pkg::INT_CHAN_W-1:0]   i_interrupt_channel,
  output logic                              o_cfg_interrupt,
  output logic [pcie_pkg::INT_CHAN_W-1:0]   o_cfg_interrupt_di,
  input  logic                              i_cfg_interrupt_rdy
);

  import pcie_pkg::*;

  logic ctrl_valid;
  logic ctrl_ready;
  logic data_valid;
  logic data_ready;

  pcie_rx_router u_rx_router (
    .i_rx_valid   (i_rx_valid),
    .i_rx_bar_hit (i_rx_bar_hit),
    .i_ctrl_ready (ctrl_ready),
    .i_data_ready (data_ready),
    .o_rx_ready   (o_rx_ready),
    .o_ctrl_valid (ctrl_valid),
    .o_data_valid (data_valid)
  );

  // Data and last fan out to both FIFOs, only valid is steered
  pcie_stream_fifo #(
    .ADDR_W (CTRL_FIFO_AW)
  ) u_ctrl_fifo (
    .clk_62p5   (clk_62p5),
    .pcie_reset (pcie_reset),
    .i_data     (i_rx_data),
    .i_last     (i_rx_last),
    .i_valid    (ctrl_valid),
    .o_ready    (ctrl_ready),
    .o_data     (o_cmd_data),
    .o_last     (o_cmd_last),
    .o_valid    (o_cmd_valid),
    .i_ready    (i_cmd_ready)
  );

  pcie_stream_fifo #(
    .ADDR_W (DATA_FIFO_AW)
  ) u_data_fifo (
    .clk_62p5   (clk_62p5),
    .pcie_reset (pcie_reset),
    .i_data     (i_rx_data),
    .i_last     (i_rx_last),
    .i_valid    (data_valid),
    .o_ready    (data_ready),
    .o_data     (o_dat_data),
    .o_last     (o_dat_last),
    .o_valid    (o_dat_valid),
    .i_ready    (i_dat_ready)
  );

  pcie_bar_reader u_bar_reader (
    .clk_62p5         (clk_62p5),
    .pcie_reset       (pcie_reset),
    .i_read_bar_stb   (i_read_bar_stb),
    .i_cfg_do         (i_cfg_do),
    .i_cfg_rd_wr_done (i_cfg_rd_wr_done),
    .o_cfg_rd_en      (o_cfg_rd_en),
    .o_cfg_dwaddr     (o_cfg_dwaddr),
    .o_bar_busy       (o_bar_busy),
    .o_bar_addr0      (o_bar_addr0),
    .o_bar_addr1      (o_bar_addr1),
    .o_bar_addr2      (o_bar_addr2),
    .o_bar_addr3      (o_bar_addr3),
    .o_bar_addr4      (o_bar_addr4),
    .o_bar_addr5      (o_bar_addr5)
  );

  pcie_interrupt_ctrl u_interrupt_ctrl (
    .clk_62p5            (clk_62p5),
    .pcie_reset          (pcie_reset),
    .i_interrupt_stb     (i_interrupt_stb),
    .i_interrupt_channel (i_interrupt_channel),
    .i_cfg_interrupt_rdy (i_cfg_interrupt_rdy),
    .o_cfg_interrupt     (o_cfg_interrupt),
    .o_cfg_interrupt_di  (o_cfg_interrupt_di)
  );

endmodule

// File: tb_clock_gen.sv
/*
  Testbench clock and reset source. Free-running 8 ns clock, with reset held
  high for the first 10 rising edges.
*/
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_62p5,
  output logic pcie_reset
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk_62p5 = 1'b0;
    forever #HALF_PERIOD clk_62p5 = ~clk_62p5;
  end

  initial begin
    pcie_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_62p5);
    pcie_reset <= 1'b0;
  end

endmodule

// File: tb_checker.sv
/*
  Checker for the endpoint glue. Models both FIFO paths with queues, the BAR
  sweep and the interrupt handshake, and compares the DUT once per cycle.
*/
`timescale 1ns/1ns

module tb_checker (
  input  logic                              clk_62p5,
  input  logic                              pcie_reset,
  input  logic [pcie_pkg::WORD_W-1:0]       i_rx_data,
  input  logic                              i_rx_last,
  input  logic                              i_rx_valid,
  input  logic [pcie_pkg::BAR_HIT_W-1:0]    i_rx_bar_hit,
  input  logic                              i_rx_ready,
  input  logic [pcie_pkg::WORD_W-1:0]       i_cmd_data,
  input  logic                              i_cmd_last,
  input  logic                              i_cmd_valid,
  input  logic                              i_cmd_ready,
  input  logic [pcie_pkg::WORD_W-1:0]       i_dat_data,
  input  logic                              i_dat_last,
  input  logic                              i_dat_valid,
  input  logic                              i_dat_ready,
  input  logic                              i_cfg_rd_en,
  input  logic [pcie_pkg::CFG_DWADDR_W-1:0] i_cfg_dwaddr,
  input  logic                              i_cfg_rd_wr_done,
  input  logic                              i_bar_busy,
  input  logic [pcie_pkg::WORD_W-1:0]       i_bar_addr0,
  input  logic [pcie_pkg::WORD_W-1:0]       i_bar_addr1,
  input  logic [pcie_pkg::WORD_W-1:0]       i_bar_addr2,
  input  logic [pcie_pkg::WORD_W-1:0]       i_bar_addr3,
  input  logic [pcie_pkg::WORD_W-1:0]       i_bar_addr4,
  input  logic [pcie_pkg::WORD_W-1:0]       i_bar_addr5,
  input  logic                              i_interrupt_stb,
  input  logic [pcie_pkg::INT_CHAN_W-1:0]   i_interrupt_channel,
  input  logic                              i_cfg_interrupt,
  input  logic [pcie_pkg::INT_CHAN_W-1:0]   i_cfg_interrupt_di,
  input  logic                              i_cfg_interrupt_rdy,
  input  logic                              i_final,
  output int                                o_errors
);

  import pcie_pkg::*;

  localparam int CTRL_DEPTH = 1 << CTRL_FIFO_AW;
  localparam int DATA_DEPTH = 1 << DATA_FIFO_AW;

  // Entries hold {last, data}
  logic [WORD_W:0]       cmd_q [$];
  logic [WORD_W:0]       dat_q [$];
  logic [WORD_W:0]       head;
  logic [INT_CHAN_W-1:0] int_chan;
  logic                  int_pend;
  logic                  prev_busy;
  logic                  final_done;
  logic                  exp_ready;
  int                    err_count;
  int                    check_count;
  int                    read_idx;
  int                    sweeps;
  int                    ints_raised;
  int                    cmd_words;
  int                    dat_words;

  assign o_errors = err_count;

  // Config space contents seen by the sweep
  function automatic logic [WORD_W-1:0] cfg_value(input logic [CFG_DWADDR_W-1:0] addr);
    return {addr, addr, addr, 2'b01} ^ 32'h5EED_C0DE;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERROR %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report(input string msg);
    err_count++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  initial begin
    err_count   = 0;
    check_count = 0;
    read_idx    = 0;
    sweeps      = 0;
    ints_raised = 0;
    cmd_words   = 0;
    dat_words   = 0;
    int_pend    = 1'b0;
    int_chan    = '0;
    prev_busy   = 1'b0;
    final_done  = 1'b0;
  end

  // Sample just before the rising edge when all inputs have settled
  always @(negedge clk_62p5) begin
    #3;
    if (pcie_reset) begin
      check_value("o_cmd_valid", 32'(1'b0), 32'(i_cmd_valid));
      check_value("o_dat_valid", 32'(1'b0), 32'(i_dat_valid));
      check_value("o_cfg_rd_en", 32'(1'b0), 32'(i_cfg_rd_en));
      check_value("o_bar_busy", 32'(1'b0), 32'(i_bar_busy));
      check_value("o_cfg_interrupt", 32'(1'b0), 32'(i_cfg_interrupt));
      check_value("o_bar_addr0", 32'h0, i_bar_addr0);
      check_value("o_bar_addr5", 32'h0, i_bar_addr5);
      cmd_q.delete();
      dat_q.delete();
      int_pend = 1'b0;
      read_idx = 0;
    end else begin
      // Ready follows the occupancy of the selected path
      if (i_rx_bar_hit[CONTROL_SELECT]) begin
        exp_ready = (cmd_q.size() < CTRL_DEPTH);
      end else if (i_rx_bar_hit[DATA_SELECT]) begin
        exp_ready = (dat_q.size() < DATA_DEPTH);
      end else begin
        exp_ready = 1'b0;
      end
      if (i_rx_valid) begin
        check_value("o_rx_ready", 32'(exp_ready), 32'(i_rx_ready));
      end

      check_value("o_cmd_valid", 32'(cmd_q.size() != 0), 32'(i_cmd_valid));
      check_value("o_dat_valid", 32'(dat_q.size() != 0), 32'(i_dat_valid));
      if (i_cmd_valid && i_cmd_ready && cmd_q.size() != 0) begin
        head = cmd_q.pop_front();
        check_value("o_cmd_data", head[WORD_W-1:0], i_cmd_data);
        check_value("o_cmd_last", 32'(head[WORD_W]), 32'(i_cmd_last));
        cmd_words++;
      end
      if (i_dat_valid && i_dat_ready && dat_q.size() != 0) begin
        head = dat_q.pop_front();
        check_value("o_dat_data", head[WORD_W-1:0], i_dat_data);
        check_value("o_dat_last", 32'(head[WORD_W]), 32'(i_dat_last));
        dat_words++;
      end

      if (i_rx_valid && i_rx_ready) begin
        if (i_rx_bar_hit[CONTROL_SELECT]) begin
          cmd_q.push_back({i_rx_last, i_rx_data});
        end else if (i_rx_bar_hit[DATA_SELECT]) begin
          dat_q.push_back({i_rx_last, i_rx_data});
        end else begin
          report("receive beat accepted without a BAR0 or BAR1 hit");
        end
      end

      // Reads go out one at a time from BAR0 upwards
      if (i_cfg_rd_en && !i_bar_busy) begin
        report("config read issued outside a BAR sweep");
      end
      if (i_cfg_rd_en && i_cfg_rd_wr_done) begin
        check_value("o_cfg_dwaddr", 32'(BAR_DWADDR_BASE + read_idx), 32'(i_cfg_dwaddr));
        read_idx++;
      end
      if (prev_busy && !i_bar_busy) begin
        if (read_idx != NUM_BARS) begin
          report("BAR sweep ended with the wrong number of reads");
        end
        check_value("o_bar_addr0", cfg_value(CFG_DWADDR_W'(BAR_DWADDR_BASE + 0)), i_bar_addr0);
        check_value("o_bar_addr1", cfg_value(CFG_DWADDR_W'(BAR_DWADDR_BASE + 1)), i_bar_addr1);
        check_value("o_bar_addr2", cfg_value(CFG_DWADDR_W'(BAR_DWADDR_BASE + 2)), i_bar_addr2);
        check_value("o_bar_addr3", cfg_value(CFG_DWADDR_W'(BAR_DWADDR_BASE + 3)), i_bar_addr3);
        check_value("o_bar_addr4", cfg_value(CFG_DWADDR_W'(BAR_DWADDR_BASE + 4)), i_bar_addr4);
        check_value("o_bar_addr5", cfg_value(CFG_DWADDR_W'(BAR_DWADDR_BASE + 5)), i_bar_addr5);
        read_idx = 0;
        sweeps++;
      end

      // Interrupt request held until acknowledged
      check_value("o_cfg_interrupt", 32'(int_pend), 32'(i_cfg_interrupt));
      if (int_pend) begin
        check_value("o_cfg_interrupt_di", 32'(int_chan), 32'(i_cfg_interrupt_di));
        if (i_cfg_interrupt_rdy) begin
          int_pend = 1'b0;
        end
      end else if (i_interrupt_stb) begin
        int_pend = 1'b1;
        int_chan = i_interrupt_channel;
        ints_raised++;
      end

      if (i_final && !final_done) begin
        final_done = 1'b1;
        if (cmd_q.size() != 0 || dat_q.size() != 0) begin
          report("words were accepted but never came out");
        end
        if (sweeps == 0 || ints_raised == 0) begin
          report("BAR sweep or interrupt never completed");
        end
        $display("Checks %0d, errors %0d, cmd words %0d, dat words %0d, sweeps %0d, irqs %0d",
                 check_count, err_count, cmd_words, dat_words, sweeps, ints_raised);
      end
    end
    prev_busy = i_bar_busy;
  end

endmodule

// File: tb_pcie_endpoint.sv
/*
  Testbench top for the endpoint glue. Drives packets, FIFO ready patterns,
  a BAR sweep and interrupts on falling edges, and answers config reads.
*/
`timescale 1ns/1ns

module tb_pcie_endpoint;

  import pcie_pkg::*;

  localparam int NUM_PKTS      = 12;
  localparam int BP_WORDS      = 40;
  localparam int BP_HOLD       = 60;
  localparam int NUM_INTS      = 3;
  localparam int MAX_CFG_DELAY = 5;

  // Ready modes for the two drain ports
  localparam int READY_HIGH    = 1;
  localparam int READY_RANDOM  = 2;
  localparam int READY_STALL   = 3;

  // Packets are at most 16 words and random ready roughly halves throughput
  localparam int BEAT_CYCLES    = (NUM_PKTS * 16 + BP_WORDS) * 4 + BP_HOLD;
  localparam int SWEEP_CYCLES   = NUM_BARS * (MAX_CFG_DELAY + 4);
  localparam int INT_CYCLES     = NUM_INTS * 16;
  localparam int TIMEOUT_CYCLES = (BEAT_CYCLES + SWEEP_CYCLES + INT_CYCLES + 50) * 3;

  logic                    clk_62p5;
  logic                    pcie_reset;
  logic [WORD_W-1:0]       i_rx_data;
  logic                    i_rx_last;
  logic                    i_rx_valid;
  logic [BAR_HIT_W-1:0]    i_rx_bar_hit;
  logic                    o_rx_ready;
  logic [WORD_W-1:0]       o_cmd_data;
  logic                    o_cmd_last;
  logic                    o_cmd_valid;
  logic                    i_cmd_ready;
  logic [WORD_W-1:0]       o_dat_data;
  logic                    o_dat_last;
  logic                    o_dat_valid;
  logic                    i_dat_ready;
  logic                    i_read_bar_stb;
  logic                    o_cfg_rd_en;
  logic [CFG_DWADDR_W-1:0] o_cfg_dwaddr;
  logic [WORD_W-1:0]       i_cfg_do;
  logic                    i_cfg_rd_wr_done;
  logic                    o_bar_busy;
  logic [WORD_W-1:0]       o_bar_addr0;
  logic [WORD_W-1:0]       o_bar_addr1;
  logic [WORD_W-1:0]       o_bar_addr2;
  logic [WORD_W-1:0]       o_bar_addr3;
  logic [WORD_W-1:0]       o_bar_addr4;
  logic [WORD_W-1:0]       o_bar_addr5;
  logic                    i_interrupt_stb;
  logic [INT_CHAN_W-1:0]   i_interrupt_channel;
  logic                    o_cfg_interrupt;
  logic [INT_CHAN_W-1:0]   o_cfg_interrupt_di;
  logic                    i_cfg_interrupt_rdy;
  logic                    final_check;
  logic [15:0]             lfsr_q = 16'd48;
  int                      cmd_mode;
  int                      dat_mode;
  int                      err_count;

  tb_clock_gen u_clock_gen (
    .clk_62p5   (clk_62p5),
    .pcie_reset (pcie_reset)
  );

  pcie_endpoint_top uut (.*);

  tb_checker chk (
    .clk_62p5            (clk_62p5),
    .pcie_reset          (pcie_reset),
    .i_rx_data           (i_rx_data),
    .i_rx_last           (i_rx_last),
    .i_rx_valid          (i_rx_valid),
    .i_rx_bar_hit        (i_rx_bar_hit),
    .i_rx_ready          (o_rx_ready),
    .i_cmd_data          (o_cmd_data),
    .i_cmd_last          (o_cmd_last),
    .i_cmd_valid         (o_cmd_valid),
    .i_cmd_ready         (i_cmd_ready),
    .i_dat_data          (o_dat_data),
    .i_dat_last          (o_dat_last),
    .i_dat_valid         (o_dat_valid),
    .i_dat_ready         (i_dat_ready),
    .i_cfg_rd_en         (o_cfg_rd_en),
    .i_cfg_dwaddr        (o_cfg_dwaddr),
    .i_cfg_rd_wr_done    (i_cfg_rd_wr_done),
    .i_bar_busy          (o_bar_busy),
    .i_bar_addr0         (o_bar_addr0),
    .i_bar_addr1         (o_bar_addr1),
    .i_bar_addr2         (o_bar_addr2),
    .i_bar_addr3         (o_bar_addr3),
    .i_bar_addr4         (o_bar_addr4),
    .i_bar_addr5         (o_bar_addr5),
    .i_interrupt_stb     (i_interrupt_stb),
    .i_interrupt_channel (i_interrupt_channel),
    .i_cfg_interrupt     (o_cfg_interrupt),
    .i_cfg_interrupt_di  (o_cfg_interrupt_di),
    .i_cfg_interrupt_rdy (i_cfg_interrupt_rdy),
    .i_final             (final_check),
    .o_errors            (err_count)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [WORD_W-1:0] cfg_value(input logic [CFG_DWADDR_W-1:0] addr);
    return {addr, addr, addr, 2'b01} ^ 32'h5EED_C0DE;
  endfunction

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_word(input logic [BAR_HIT_W-1:0] hit, input logic [WORD_W-1:0] data,
                           input logic last);
    logic taken;
    i_rx_valid   = 1'b1;
    i_rx_bar_hit = hit;
    i_rx_data    = data;
    i_rx_last    = last;
    taken        = 1'b0;
    while (!taken) begin
      #3;
      taken = o_rx_ready;
      @(negedge clk_62p5);
    end
  endtask

  task automatic send_packet(input logic [BAR_HIT_W-1:0] hit, input int len);
    logic [31:0] data;
    for (int i = 0; i < len; i++) begin
      take_bits(WORD_W, data);
      send_word(hit, data, (i == len - 1));
    end
    i_rx_valid = 1'b0;
  endtask

  task automatic wait_drained();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      #3;
      busy = o_cmd_valid | o_dat_valid;
      @(negedge clk_62p5);
    end
  endtask

  task automatic ready_value(input int mode, output logic v);
    logic [31:0] r;
    if (mode == READY_RANDOM) begin
      take_bits(1, r);
      v = r[0];
    end else begin
      v = (mode == READY_HIGH);
    end
  endtask

  // Stall mode holds cmd ready low for a while and then goes random
  initial begin : ready_driver
    int hold_cnt;
    i_cmd_ready = 1'b0;
    i_dat_ready = 1'b0;
    hold_cnt    = 0;
    forever begin
      @(negedge clk_62p5);
      if (cmd_mode == READY_STALL && hold_cnt < BP_HOLD) begin
        hold_cnt++;
        i_cmd_ready = 1'b0;
      end else if (cmd_mode == READY_STALL) begin
        ready_value(READY_RANDOM, i_cmd_ready);
      end else begin
        hold_cnt = 0;
        ready_value(cmd_mode, i_cmd_ready);
      end
      ready_value(dat_mode, i_dat_ready);
    end
  end

  // Core side of the config read port with 0 to 5 cycles of latency
  initial begin : cfg_responder
    logic [31:0] r;
    int          delay;
    i_cfg_do         = '0;
    i_cfg_rd_wr_done = 1'b0;
    forever begin
      @(negedge clk_62p5);
      if (o_cfg_rd_en) begin
        take_bits(3, r);
        delay = int'(r[2:0]) % (MAX_CFG_DELAY + 1);
        repeat (delay) @(negedge clk_62p5);
        i_cfg_do         = cfg_value(o_cfg_dwaddr);
        i_cfg_rd_wr_done = 1'b1;
        @(negedge clk_62p5);
        i_cfg_rd_wr_done = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_62p5);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]          r;
    logic [BAR_HIT_W-1:0] hit;
    int                   hold;
    i_rx_data           = '0;
    i_rx_last           = 1'b0;
    i_rx_valid          = 1'b0;
    i_rx_bar_hit        = '0;
    i_read_bar_stb      = 1'b0;
    i_interrupt_stb     = 1'b0;
    i_interrupt_channel = '0;
    i_cfg_interrupt_rdy = 1'b0;
    final_check         = 1'b0;
    cmd_mode            = READY_HIGH;
    dat_mode            = READY_HIGH;
    @(negedge clk_62p5);
    while (pcie_reset) @(negedge clk_62p5);
    repeat (3) @(negedge clk_62p5);

    // Random packets to BAR0 and BAR1 with random drain
    cmd_mode = READY_RANDOM;
    dat_mode = READY_RANDOM;
    for (int p = 0; p < NUM_PKTS; p++) begin
      take_bits(5, r);
      hit = r[4] ? BAR_HIT_W'(1 << DATA_SELECT) : BAR_HIT_W'(1 << CONTROL_SELECT);
      send_packet(hit, int'(r[3:0]) + 1);
    end
    wait_drained();

    // Fill the control FIFO past its depth
    cmd_mode = READY_STALL;
    send_packet(BAR_HIT_W'(1 << CONTROL_SELECT), BP_WORDS);
    wait_drained();
    cmd_mode = READY_HIGH;

    // BAR sweep with a stray strobe while busy
    i_read_bar_stb = 1'b1;
    @(negedge clk_62p5);
    i_read_bar_stb = 1'b0;
    repeat (3) @(negedge clk_62p5);
    i_read_bar_stb = 1'b1;
    @(negedge clk_62p5);
    i_read_bar_stb = 1'b0;
    while (o_bar_busy) @(negedge clk_62p5);

    // Interrupts with a second strobe while each one is pending
    for (int k = 0; k < NUM_INTS; k++) begin
      take_bits(INT_CHAN_W + 3, r);
      i_interrupt_channel = r[INT_CHAN_W+2:3];
      hold = int'(r[2:0]) + 1;
      i_interrupt_stb = 1'b1;
      @(negedge clk_62p5);
      i_interrupt_channel = ~i_interrupt_channel;
      @(negedge clk_62p5);
      i_interrupt_stb = 1'b0;
      repeat (hold) @(negedge clk_62p5);
      i_cfg_interrupt_rdy = 1'b1;
      @(negedge clk_62p5);
      i_cfg_interrupt_rdy = 1'b0;
      repeat (2) @(negedge clk_62p5);
    end

    final_check = 1'b1;
    repeat (2) @(negedge clk_62p5);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
pcie_pkg.sv
pcie_rx_router.sv
pcie_stream_fifo.sv
pcie_bar_reader.sv
pcie_interrupt_ctrl.sv
pcie_endpoint_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_pcie_endpoint.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_pcie_endpoint -o tb_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation gave no result"; exit 1; }
exit 0
